// ==== sources.f ====
+incdir+src
src/apb_timer_pkg.sv
src/iob_if.sv
src/apb2iob.sv
src/timer_regs.sv
src/timer_core.sv
src/apb_timer_top.sv
test/tb_apb_timer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the APB timer testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

if ! verilator --binary --timing --timescale 1ns/1ps -f sources.f \
      --top-module tb_apb_timer -o tb_apb_timer_sim; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_apb_timer_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

// ==== test/tb_apb_timer.sv ====
/* Table-driven testbench of the APB timer. Inputs change on the falling
   clock edge, so all sampling happens half a cycle away from DUT updates. */
`include "apb_timer_settings.svh"

module tb_apb_timer;
   timeunit 1ns;
   timeprecision 1ps;

   typedef enum int {OP_WRITE, OP_READ, OP_READ_MAX, OP_IDLE, OP_IRQ} op_e;

   localparam logic [`WSTRB_W-1:0] ALL_BYTES  = '1;
   localparam int                  READY_WAIT = 10;
   localparam int                  MARGIN     = 50;

   logic                clk_i;
   logic                rst_n_i;
   logic                apb_sel_i;
   logic                apb_enable_i;
   logic                apb_write_i;
   logic [`ADDR_W-1:0]  apb_addr_i;
   logic [`DATA_W-1:0]  apb_wdata_i;
   logic [`WSTRB_W-1:0] apb_wstrb_i;
   logic [`DATA_W-1:0]  apb_rdata_o;
   logic                apb_ready_o;
   logic                irq_o;

   // One entry per row in each queue.
   string               row_name[$];
   op_e                 row_kind[$];
   logic [`ADDR_W-1:0]  row_addr[$];
   logic [`DATA_W-1:0]  row_data[$];
   logic [`WSTRB_W-1:0] row_strb[$];
   logic [`DATA_W-1:0]  row_exp[$];

   int                  error_count = 0;
   int                  check_count = 0;
   int                  cycle_count = 0;
   int                  cycle_limit = 0;
   integer              seed        = 32'h23f0_5cf8;

   apb_timer_top dut_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .apb_sel_i   (apb_sel_i),
      .apb_enable_i(apb_enable_i),
      .apb_write_i (apb_write_i),
      .apb_addr_i  (apb_addr_i),
      .apb_wdata_i (apb_wdata_i),
      .apb_wstrb_i (apb_wstrb_i),
      .apb_rdata_o (apb_rdata_o),
      .apb_ready_o (apb_ready_o),
      .irq_o       (irq_o)
   );

   always #4 clk_i = ~clk_i;

   task automatic add_row(input string name, input op_e kind, input logic [`ADDR_W-1:0] addr,
                          input logic [`DATA_W-1:0] data, input logic [`WSTRB_W-1:0] strb,
                          input logic [`DATA_W-1:0] exp_val);
      row_name.push_back(name);
      row_kind.push_back(kind);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_strb.push_back(strb);
      row_exp.push_back(exp_val);
   endtask

   task automatic build_table();
      logic [`DATA_W-1:0] rnd_a;
      logic [`DATA_W-1:0] rnd_b;
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      add_row("status_after_reset", OP_READ, `ADDR_STATUS, '0, '0, 32'h0);
      add_row("count_after_reset", OP_READ, `ADDR_COUNT, '0, '0, 32'h0);
      add_row("load_wr_a", OP_WRITE, `ADDR_LOAD, rnd_a, ALL_BYTES, '0);
      add_row("load_rd_a", OP_READ, `ADDR_LOAD, '0, '0, rnd_a);
      add_row("load_wr_b", OP_WRITE, `ADDR_LOAD, rnd_b, ALL_BYTES, '0);
      add_row("load_rd_b", OP_READ, `ADDR_LOAD, '0, '0, rnd_b);
      // Reserved CTRL bits drop, irq_en and auto_reload stay.
      add_row("ctrl_wr_raw", OP_WRITE, `ADDR_CTRL, 32'hA5A5_A5FE, ALL_BYTES, '0);
      add_row("ctrl_rd_raw", OP_READ, `ADDR_CTRL, '0, '0, 32'h0000_0006);
      add_row("ctrl_wr_zero", OP_WRITE, `ADDR_CTRL, 32'h0, ALL_BYTES, '0);
      add_row("ctrl_rd_zero", OP_READ, `ADDR_CTRL, '0, '0, 32'h0);
      add_row("load_wr_byte2", OP_WRITE, `ADDR_LOAD, 32'hDEAD_BEEF, 4'b0100, '0);
      add_row("load_rd_byte2", OP_READ, `ADDR_LOAD, '0, '0,
              (rnd_b & 32'hFF00_FFFF) | 32'h00AD_0000);
      add_row("load_wr_hold", OP_WRITE, `ADDR_LOAD, 32'h0000_1234, ALL_BYTES, '0);
      add_row("idle_hold", OP_IDLE, '0, 32'd6, '0, '0);
      add_row("count_rd_hold", OP_READ, `ADDR_COUNT, '0, '0, 32'h0000_1234);
      // One-shot run from 5.
      add_row("load_wr_5", OP_WRITE, `ADDR_LOAD, 32'd5, ALL_BYTES, '0);
      add_row("ctrl_wr_en", OP_WRITE, `ADDR_CTRL, 32'h1, ALL_BYTES, '0);
      add_row("idle_oneshot", OP_IDLE, '0, 32'd20, '0, '0);
      add_row("count_rd_oneshot", OP_READ, `ADDR_COUNT, '0, '0, 32'h0);
      add_row("status_rd_oneshot", OP_READ, `ADDR_STATUS, '0, '0, 32'h1);
      add_row("irq_low_masked", OP_IRQ, '0, '0, '0, 32'h0);
      add_row("ctrl_wr_irq_en", OP_WRITE, `ADDR_CTRL, 32'h5, ALL_BYTES, '0);
      add_row("idle_irq", OP_IDLE, '0, 32'd2, '0, '0);
      add_row("irq_high", OP_IRQ, '0, '0, '0, 32'h1);
      add_row("ctrl_rd_irq_en", OP_READ, `ADDR_CTRL, '0, '0, 32'h5);
      add_row("status_wr_clear", OP_WRITE, `ADDR_STATUS, 32'h1, ALL_BYTES, '0);
      add_row("idle_clear", OP_IDLE, '0, 32'd2, '0, '0);
      add_row("irq_low_cleared", OP_IRQ, '0, '0, '0, 32'h0);
      add_row("status_rd_cleared", OP_READ, `ADDR_STATUS, '0, '0, 32'h0);
      // Auto-reload run from 3, stopped first so counting starts from 3.
      add_row("ctrl_wr_stop", OP_WRITE, `ADDR_CTRL, 32'h0, ALL_BYTES, '0);
      add_row("load_wr_3", OP_WRITE, `ADDR_LOAD, 32'd3, ALL_BYTES, '0);
      add_row("ctrl_wr_reload", OP_WRITE, `ADDR_CTRL, 32'h3, ALL_BYTES, '0);
      add_row("idle_reload", OP_IDLE, '0, 32'd12, '0, '0);
      add_row("count_rd_reload", OP_READ_MAX, `ADDR_COUNT, '0, '0, 32'd3);
      add_row("status_rd_reload", OP_READ, `ADDR_STATUS, '0, '0, 32'h1);
      // A one-shot timer would never expire again after this clear.
      add_row("status_wr_clear_reload", OP_WRITE, `ADDR_STATUS, 32'h1, ALL_BYTES, '0);
      add_row("idle_reload_again", OP_IDLE, '0, 32'd8, '0, '0);
      add_row("status_rd_reload_again", OP_READ, `ADDR_STATUS, '0, '0, 32'h1);
      add_row("irq_low_reload", OP_IRQ, '0, '0, '0, 32'h0);
   endtask

   function automatic int row_cycles(input int i);
      case (row_kind[i])
         OP_WRITE: return 4;
         OP_IDLE:  return int'(row_data[i]);
         OP_IRQ:   return 0;
         default:  return 5;
      endcase
   endfunction

   // Setup phase, access phase, then wait for ready. Starts and ends on a falling edge.
   task automatic apb_transfer(input logic write, input logic [`ADDR_W-1:0] addr,
                               input logic [`DATA_W-1:0] wdata,
                               input logic [`WSTRB_W-1:0] strb,
                               output logic [`DATA_W-1:0] rdata, output logic ok);
      int waited;
      waited       = 0;
      ok           = 1'b0;
      rdata        = '0;
      apb_sel_i    = 1'b1;
      apb_enable_i = 1'b0;
      apb_write_i  = write;
      apb_addr_i   = addr;
      apb_wdata_i  = wdata;
      apb_wstrb_i  = write ? strb : '0;
      @(negedge clk_i);
      apb_enable_i = 1'b1;
      while (!ok && waited < READY_WAIT) begin
         @(negedge clk_i);
         waited++;
         if (apb_ready_o) begin
            ok    = 1'b1;
            rdata = apb_rdata_o;
         end
      end
      // Hold through the completing rising edge.
      @(negedge clk_i);
      apb_sel_i    = 1'b0;
      apb_enable_i = 1'b0;
      apb_write_i  = 1'b0;
      apb_wstrb_i  = '0;
   endtask

   task automatic apply_row(input int i);
      logic [`DATA_W-1:0] rdata;
      logic               ok;
      case (row_kind[i])
         OP_IDLE: begin
            repeat (row_data[i]) @(negedge clk_i);
         end
         OP_IRQ: begin
            check_count++;
            if (irq_o !== row_exp[i][0]) begin
               error_count++;
               $display("mismatch %s: expected %0h, actual %0h", row_name[i], row_exp[i][0],
                        irq_o);
            end
         end
         default: begin
            apb_transfer(row_kind[i] == OP_WRITE, row_addr[i], row_data[i], row_strb[i],
                         rdata, ok);
            if (!ok) begin
               error_count++;
               $display("%s: no apb_ready_o within %0d cycles", row_name[i], READY_WAIT);
            end else if (row_kind[i] == OP_READ) begin
               check_count++;
               if (rdata !== row_exp[i]) begin
                  error_count++;
                  $display("mismatch %s: expected %h, actual %h", row_name[i], row_exp[i],
                           rdata);
               end
            end else if (row_kind[i] == OP_READ_MAX) begin
               check_count++;
               if (rdata > row_exp[i]) begin
                  error_count++;
                  $display("mismatch %s: expected at most %h, actual %h", row_name[i],
                           row_exp[i], rdata);
               end
            end
         end
      endcase
   endtask

   initial begin : watchdog
      @(posedge clk_i);
      while (cycle_count < cycle_limit) begin
         @(posedge clk_i);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display("checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : main
      int total;
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      apb_sel_i    = 1'b0;
      apb_enable_i = 1'b0;
      apb_write_i  = 1'b0;
      apb_addr_i   = '0;
      apb_wdata_i  = '0;
      apb_wstrb_i  = '0;
      build_table();
      total = 3 + MARGIN;
      for (int i = 0; i < row_name.size(); i++) begin
         total += row_cycles(i);
      end
      cycle_limit = total;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      for (int i = 0; i < row_name.size(); i++) begin
         apply_row(i);
      end
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== src/apb_timer_top.sv ====
/* APB timer with one down counter and a level interrupt.
   APB without PPROT and PSLVERR; only address bits 3..2 are decoded. */
`include "apb_timer_settings.svh"

module apb_timer_top (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                apb_sel_i,
   input  logic                apb_enable_i,
   input  logic                apb_write_i,
   input  logic [`ADDR_W-1:0]  apb_addr_i,
   input  logic [`DATA_W-1:0]  apb_wdata_i,
   input  logic [`WSTRB_W-1:0] apb_wstrb_i,
   output logic [`DATA_W-1:0]  apb_rdata_o,
   output logic                apb_ready_o,
   output logic                irq_o
);
   apb_timer_pkg::ctrl_word_u ctrl;
   logic [`DATA_W-1:0]        load_value;
   logic                      load_stb;
   logic [`DATA_W-1:0]        count;
   logic                      expire_stb;

   iob_if iob_bus ();

   apb2iob bridge_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .apb_sel_i   (apb_sel_i),
      .apb_enable_i(apb_enable_i),
      .apb_write_i (apb_write_i),
      .apb_addr_i  (apb_addr_i),
      .apb_wdata_i (apb_wdata_i),
      .apb_wstrb_i (apb_wstrb_i),
      .apb_rdata_o (apb_rdata_o),
      .apb_ready_o (apb_ready_o),
      .bus_o       (iob_bus)
   );

   timer_regs regs_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .bus_i       (iob_bus),
      .ctrl_o      (ctrl),
      .load_value_o(load_value),
      .load_stb_o  (load_stb),
      .count_i     (count),
      .expire_stb_i(expire_stb),
      .irq_o       (irq_o)
   );

   timer_core core_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ctrl_i      (ctrl),
      .load_value_i(load_value),
      .load_stb_i  (load_stb),
      .count_o     (count),
      .expire_stb_o(expire_stb)
   );

endmodule

// ==== src/timer_core.sv ====
/* Down counter of the timer. Counts one per clock while enabled.
   A load always wins; auto-reload restarts from the LOAD value after expiry. */
`include "apb_timer_settings.svh"

module timer_core (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  apb_timer_pkg::ctrl_word_u ctrl_i,
   input  logic [`DATA_W-1:0]        load_value_i,
   input  logic                      load_stb_i,
   output logic [`DATA_W-1:0]        count_o,
   output logic                      expire_stb_o
);
   localparam logic [`DATA_W-1:0] COUNT_ONE = {{(`DATA_W-1){1'b0}}, 1'b1};

   logic [`DATA_W-1:0] count_q;
   logic               expire_q;
   logic               last_tick;
   logic               reload;

   // The step from 1 to 0 is the expiry.
   assign last_tick = ctrl_i.f.enable && (count_q == COUNT_ONE) && !load_stb_i;

   // Reload happens on the edge after the expiry pulse.
   assign reload = expire_q && ctrl_i.f.auto_reload;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q  <= '0;
         expire_q <= 1'b0;
      end else begin
         expire_q <= last_tick;
         if (load_stb_i) begin
            count_q <= load_value_i;
         end else if (ctrl_i.f.enable) begin
            if (count_q != '0) begin
               count_q <= count_q - COUNT_ONE;
            end else if (reload) begin
               count_q <= load_value_i;
            end
         end
      end
   end

   assign count_o      = count_q;
   assign expire_stb_o = expire_q;

endmodule

// ==== src/timer_regs.sv ====
/* Timer register block on the request bus: CTRL, LOAD, COUNT (read only)
   and STATUS (write 1 to clear). Read data returns one cycle after accept. */
`include "apb_timer_settings.svh"

module timer_regs (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   iob_if.subordinate                bus_i,
   output apb_timer_pkg::ctrl_word_u ctrl_o,
   output logic [`DATA_W-1:0]        load_value_o,
   output logic                      load_stb_o,
   input  logic [`DATA_W-1:0]        count_i,
   input  logic                      expire_stb_i,
   output logic                      irq_o
);
   apb_timer_pkg::reg_idx_e   idx;
   apb_timer_pkg::ctrl_word_u ctrl_q;
   apb_timer_pkg::ctrl_word_u ctrl_wr;
   logic [`DATA_W-1:0]        load_q;
   logic                      load_stb_q;
   logic                      expired_q;
   logic                      irq_q;
   logic                      rvalid_q;
   logic [`DATA_W-1:0]        rdata_q;
   logic [`DATA_W-1:0]        rd_word;
   logic                      accept;
   logic                      wr_en;
   logic                      rd_en;
   logic                      status_clr;

   function automatic logic [`DATA_W-1:0] merge_bytes(
      input logic [`DATA_W-1:0]  old_val,
      input logic [`DATA_W-1:0]  new_val,
      input logic [`WSTRB_W-1:0] strb
   );
      logic [`DATA_W-1:0] res;
      res = old_val;
      for (int i = 0; i < `WSTRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return res;
   endfunction

   assign idx    = apb_timer_pkg::reg_idx_e'(bus_i.addr[3:2]);
   assign accept = bus_i.valid & bus_i.ready;
   assign wr_en  = accept & (bus_i.wstrb != '0);
   assign rd_en  = accept & (bus_i.wstrb == '0);

   assign status_clr = wr_en && (idx == apb_timer_pkg::STATUS) &&
                       bus_i.wstrb[0] && bus_i.wdata[0];

   // Bytes land in the raw view, reserved bits are forced back to zero.
   always_comb begin
      ctrl_wr.raw        = merge_bytes(ctrl_q.raw, bus_i.wdata, bus_i.wstrb);
      ctrl_wr.f.reserved = '0;
   end

   always_comb begin
      case (idx)
         apb_timer_pkg::CTRL:  rd_word = ctrl_q.raw;
         apb_timer_pkg::LOAD:  rd_word = load_q;
         apb_timer_pkg::COUNT: rd_word = count_i;
         default:              rd_word = {{(`DATA_W-1){1'b0}}, expired_q};
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q     <= '0;
         load_q     <= '0;
         load_stb_q <= 1'b0;
         expired_q  <= 1'b0;
         irq_q      <= 1'b0;
         rvalid_q   <= 1'b0;
      end else begin
         load_stb_q <= wr_en && (idx == apb_timer_pkg::LOAD);
         if (wr_en && (idx == apb_timer_pkg::CTRL)) begin
            ctrl_q <= ctrl_wr;
         end
         if (wr_en && (idx == apb_timer_pkg::LOAD)) begin
            load_q <= merge_bytes(load_q, bus_i.wdata, bus_i.wstrb);
         end
         // A new expiry beats a clear in the same cycle.
         if (expire_stb_i) begin
            expired_q <= 1'b1;
         end else if (status_clr) begin
            expired_q <= 1'b0;
         end
         irq_q <= expired_q & ctrl_q.f.irq_en;
         if (rvalid_q && bus_i.rready) begin
            rvalid_q <= 1'b0;
         end
         if (rd_en) begin
            rvalid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rd_word;
      end
   end

   // No new request while a read response waits.
   assign bus_i.ready  = ~rvalid_q;
   assign bus_i.rvalid = rvalid_q;
   assign bus_i.rdata  = rdata_q;

   assign ctrl_o       = ctrl_q;
   assign load_value_o = load_q;
   assign load_stb_o   = load_stb_q;
   assign irq_o        = irq_q;

endmodule

// ==== src/apb2iob.sv ====
/* APB subordinate to request-bus manager. No PPROT or PSLVERR.
   Writes finish one cycle after the access phase starts, reads two. */
`include "apb_timer_settings.svh"

module apb2iob (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                apb_sel_i,
   input  logic                apb_enable_i,
   input  logic                apb_write_i,
   input  logic [`ADDR_W-1:0]  apb_addr_i,
   input  logic [`DATA_W-1:0]  apb_wdata_i,
   input  logic [`WSTRB_W-1:0] apb_wstrb_i,
   output logic [`DATA_W-1:0]  apb_rdata_o,
   output logic                apb_ready_o,
   iob_if.manager              bus_o
);
   localparam logic [1:0] WAIT_ENABLE = 2'd0;
   localparam logic [1:0] WAIT_READY  = 2'd1;
   localparam logic [1:0] WAIT_RVALID = 2'd2;
   localparam logic [1:0] READY_PULSE = 2'd3;

   logic [1:0]          state_q;
   logic [1:0]          state_nxt;
   logic                req_valid;
   logic                rready;
   logic                apb_ready_nxt;
   logic [`WSTRB_W-1:0] req_wstrb;

   // Strobes are masked so the subordinate sees a read.
   assign req_wstrb    = apb_write_i ? apb_wstrb_i : '0;

   assign bus_o.valid  = req_valid;
   assign bus_o.addr   = apb_addr_i;
   assign bus_o.wdata  = apb_wdata_i;
   assign bus_o.wstrb  = req_wstrb;
   assign bus_o.rready = rready;

   always_comb begin
      state_nxt     = state_q;
      req_valid     = 1'b0;
      rready        = 1'b0;
      apb_ready_nxt = 1'b0;

      case (state_q)
         WAIT_ENABLE: begin
            req_valid = apb_sel_i & apb_enable_i;
         end
         WAIT_READY: begin
            req_valid = 1'b1;
         end
         WAIT_RVALID: begin
            rready = 1'b1;
            if (bus_o.rvalid) begin
               apb_ready_nxt = 1'b1;
               state_nxt     = READY_PULSE;
            end
         end
         default: begin
            // APB ready is high this cycle, the transfer ends here.
            state_nxt = WAIT_ENABLE;
         end
      endcase

      // Only one request leaves per transfer, it stays up until accepted.
      if (req_valid) begin
         if (!bus_o.ready) begin
            state_nxt = WAIT_READY;
         end else if (req_wstrb != '0) begin
            apb_ready_nxt = 1'b1;
            state_nxt     = READY_PULSE;
         end else begin
            state_nxt = WAIT_RVALID;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= WAIT_ENABLE;
         apb_ready_o <= 1'b0;
      end else begin
         state_q     <= state_nxt;
         apb_ready_o <= apb_ready_nxt;
      end
   end

   // Read data is held for the APB data phase.
   always_ff @(posedge clk_i) begin
      if (rready && bus_o.rvalid) begin
         apb_rdata_o <= bus_o.rdata;
      end
   end

endmodule

// ==== src/iob_if.sv ====
/* Internal valid/ready request bus. An all-zero wstrb marks a read,
   whose data returns later on rvalid/rready. */
`include "apb_timer_settings.svh"

interface iob_if;
   logic                valid;
   logic [`ADDR_W-1:0]  addr;
   logic [`DATA_W-1:0]  wdata;
   logic [`WSTRB_W-1:0] wstrb;
   logic                ready;
   logic                rvalid;
   logic [`DATA_W-1:0]  rdata;
   logic                rready;

   modport manager (
      output valid, addr, wdata, wstrb, rready,
      input  ready, rvalid, rdata
   );

   modport subordinate (
      input  valid, addr, wdata, wstrb, rready,
      output ready, rvalid, rdata
   );
endinterface

// ==== src/apb_timer_pkg.sv ====
/* Shared types of the APB timer.
   The control word layout assumes DATA_W of at least 4 bits. */
`include "apb_timer_settings.svh"

package apb_timer_pkg;

   // Field view of CTRL. Bit 0 is the LSB, so it is listed last.
   typedef struct packed {
      logic [`DATA_W-4:0] reserved;
      logic               irq_en;
      logic               auto_reload;
      logic               enable;
   } ctrl_fields_t;

   // Software writes bytes of raw, the core reads the fields.
   typedef union packed {
      logic [`DATA_W-1:0] raw;
      ctrl_fields_t       f;
   } ctrl_word_u;

   // Register index, taken from address bits 3..2.
   typedef enum logic [1:0] {
      CTRL   = 2'(`ADDR_CTRL >> 2),
      LOAD   = 2'(`ADDR_LOAD >> 2),
      COUNT  = 2'(`ADDR_COUNT >> 2),
      STATUS = 2'(`ADDR_STATUS >> 2)
   } reg_idx_e;

endpackage

// ==== src/apb_timer_settings.svh ====
/* Bus widths and register map of the APB timer.
   DATA_W must be a multiple of 8. The map uses address bits 3..2 only. */
`ifndef APB_TIMER_SETTINGS_SVH
`define APB_TIMER_SETTINGS_SVH

`define DATA_W  32
`define ADDR_W  4
`define WSTRB_W (`DATA_W / 8)

// Register byte offsets.
`define ADDR_CTRL   4'h0
`define ADDR_LOAD   4'h4
`define ADDR_COUNT  4'h8
`define ADDR_STATUS 4'hC

`endif
